//--- design/board_macros.svh
// port count, synchronizer depth and power-up sequence times
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// qsfp28 cages on the board
`define BRD_PORT_CNT 4
// flip-flop ranks on asynchronous pins
`define BRD_SYNC_STAGES 2
// cycles of module reset after insertion
`define BRD_RESET_HOLD 16
// cycles in low-power mode before the port is ready
`define BRD_INIT_WAIT 32

`endif

//--- design/board_pkg.sv
// port-state enum, port mask, port index and event flag types
`include "board_macros.svh"

package board_pkg;

    // cage power-up sequence states
    typedef enum logic [1:0] {
        ABSENT = 2'd0,
        HOLD   = 2'd1,
        INIT   = 2'd2,
        READY  = 2'd3
    } port_state_e;

    // one bit per cage
    typedef logic [`BRD_PORT_CNT-1:0] port_mask_t;

    // cage index
    typedef logic [1:0] port_idx_t;

    // sticky event bits of one cage
    typedef struct packed {
        logic insert;
        logic remove;
        logic intr;
    } port_evt_t;

    // events of all cages, cage 0 in the low bits
    typedef port_evt_t [`BRD_PORT_CNT-1:0] port_evt_arr_t;

endpackage

//--- design/qsfp_stat_if.sv
// qsfp_stat_if interface with mgr and agg modports
`timescale 1ns/10ps

interface qsfp_stat_if;
    import board_pkg::*;

    logic        present;
    logic        ready;
    port_state_e state;
    // single-cycle event strobes, no back-pressure
    logic        insert_stb;
    logic        remove_stb;
    logic        intr_stb;

    modport mgr (
        output present, ready, state,
        output insert_stb, remove_stb, intr_stb
    );

    modport agg (
        input present, ready, state,
        input insert_stb, remove_stb, intr_stb
    );

endinterface

//--- design/sig_sync.sv
// sig_sync module, multi-rank synchronizer for asynchronous pins
`timescale 1ns/10ps
`include "board_macros.svh"

module sig_sync #(
    parameter int WIDTH  = 1,
    parameter int STAGES = `BRD_SYNC_STAGES
) (
    input  logic             clk_125mhz_int,
    input  logic             rst_n_i,
    input  logic [WIDTH-1:0] async_i,
    output logic [WIDTH-1:0] sync_o
);

    logic [WIDTH-1:0] sync_q [STAGES];

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n_i) begin
            // pins are active low, so ones are the idle level
            for (int s = 0; s < STAGES; s++) begin
                sync_q[s] <= '1;
            end
        end else begin
            sync_q[0] <= async_i;
            for (int s = 1; s < STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    // last rank drives the clock-domain copy
    assign sync_o = sync_q[STAGES-1];

endmodule

//--- design/qsfp_port_mgr.sv
// qsfp_port_mgr module, per-cage power-up sequencer and event strobes
`timescale 1ns/10ps
`include "board_macros.svh"

module qsfp_port_mgr #(
    parameter int RESET_HOLD = `BRD_RESET_HOLD,
    parameter int INIT_WAIT  = `BRD_INIT_WAIT
) (
    input  logic            clk_125mhz_int,
    input  logic            rst_n_i,
    input  logic            modprsl_i,
    input  logic            intl_i,
    input  logic            enable_i,
    output logic            resetl_o,
    output logic            lpmode_o,
    qsfp_stat_if.mgr        stat
);
    import board_pkg::*;

    localparam int CNT_MAX = (RESET_HOLD > INIT_WAIT) ? RESET_HOLD : INIT_WAIT;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    // counter reloads, the state lasts load + 1 cycles
    localparam logic [CNT_W-1:0] HOLD_LOAD = CNT_W'(RESET_HOLD - 1);
    localparam logic [CNT_W-1:0] INIT_LOAD = CNT_W'(INIT_WAIT - 1);

    port_state_e      state_q;
    port_state_e      state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;

    logic present;
    logic intr_act;
    logic qualified;
    logic intr_q;

    logic insert_d;
    logic remove_d;
    logic intr_d;
    logic insert_stb_q;
    logic remove_stb_q;
    logic intr_stb_q;

    // active-high views of the synchronized pins
    assign present   = ~modprsl_i;
    assign intr_act  = ~intl_i;
    assign qualified = present & enable_i;

    always_comb begin
        state_d  = state_q;
        cnt_d    = cnt_q;
        insert_d = 1'b0;
        remove_d = 1'b0;

        case (state_q)
            ABSENT: begin
                if (qualified) begin
                    state_d  = HOLD;
                    cnt_d    = HOLD_LOAD;
                    insert_d = 1'b1;
                end
            end
            HOLD: begin
                if (!qualified) begin
                    state_d  = ABSENT;
                    remove_d = 1'b1;
                end else if (cnt_q == '0) begin
                    // release reset, stay in low-power mode
                    state_d = INIT;
                    cnt_d   = INIT_LOAD;
                end else begin
                    cnt_d = cnt_q - 1'b1;
                end
            end
            INIT: begin
                if (!qualified) begin
                    state_d  = ABSENT;
                    remove_d = 1'b1;
                end else if (cnt_q == '0) begin
                    state_d = READY;
                end else begin
                    cnt_d = cnt_q - 1'b1;
                end
            end
            READY: begin
                if (!qualified) begin
                    state_d  = ABSENT;
                    remove_d = 1'b1;
                end
            end
            default: begin
                state_d = ABSENT;
            end
        endcase
    end

    // falling intl only counts while the port stays ready
    assign intr_d = (state_q == READY) && qualified && intr_act && !intr_q;

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n_i) begin
            state_q      <= ABSENT;
            cnt_q        <= '0;
            intr_q       <= 1'b0;
            insert_stb_q <= 1'b0;
            remove_stb_q <= 1'b0;
            intr_stb_q   <= 1'b0;
        end else begin
            state_q      <= state_d;
            cnt_q        <= cnt_d;
            intr_q       <= intr_act;
            insert_stb_q <= insert_d;
            remove_stb_q <= remove_d;
            intr_stb_q   <= intr_d;
        end
    end

    // module pins decode straight from the state register
    assign resetl_o = (state_q == INIT) || (state_q == READY);
    assign lpmode_o = (state_q != READY);

    assign stat.present    = present;
    assign stat.ready      = (state_q == READY);
    assign stat.state      = state_q;
    assign stat.insert_stb = insert_stb_q;
    assign stat.remove_stb = remove_stb_q;
    assign stat.intr_stb   = intr_stb_q;

endmodule

//--- design/port_status_agg.sv
// port_status_agg module, sticky event flags, interrupt output and ready LEDs
`timescale 1ns/10ps
`include "board_macros.svh"

module port_status_agg (
    input  logic                     clk_125mhz_int,
    input  logic                     rst_n_i,
    qsfp_stat_if.agg                 stat [`BRD_PORT_CNT],
    input  logic                     evt_clr_stb_i,
    input  board_pkg::port_idx_t     evt_clr_port_i,
    output board_pkg::port_evt_arr_t evt_flags_o,
    output logic                     irq_o,
    output board_pkg::port_mask_t    led_o
);
    import board_pkg::*;

    port_evt_arr_t evt_set;
    port_evt_arr_t flags_q;
    port_mask_t    ready_vec;

    // gather strobes and ready bits from the interface array
    for (genvar i = 0; i < `BRD_PORT_CNT; i++) begin : g_port
        assign evt_set[i].insert = stat[i].insert_stb;
        assign evt_set[i].remove = stat[i].remove_stb;
        assign evt_set[i].intr   = stat[i].intr_stb;
        assign ready_vec[i]      = stat[i].ready && stat[i].present;
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (!rst_n_i) begin
            flags_q <= '0;
            irq_o   <= 1'b0;
            led_o   <= '0;
        end else begin
            for (int i = 0; i < `BRD_PORT_CNT; i++) begin
                if (evt_clr_stb_i && (evt_clr_port_i == port_idx_t'(i))) begin
                    // a new event in the clear cycle survives
                    flags_q[i] <= evt_set[i];
                end else begin
                    flags_q[i] <= flags_q[i] | evt_set[i];
                end
            end
            irq_o <= |flags_q;
            led_o <= ready_vec;
        end
    end

    assign evt_flags_o = flags_q;

endmodule

//--- design/qsfp_mgmt_top.sv
// qsfp_mgmt_top module, pin synchronizer, four cage managers and status aggregator
`timescale 1ns/10ps
`include "board_macros.svh"

module qsfp_mgmt_top (
    input  logic                       clk_125mhz_int,
    input  logic                       rst_n_i,

    // cage sideband pins, active low and asynchronous
    input  logic [`BRD_PORT_CNT-1:0]   qsfp_modprsl_i,
    input  logic [`BRD_PORT_CNT-1:0]   qsfp_intl_i,
    output logic [`BRD_PORT_CNT-1:0]   qsfp_resetl_o,
    output logic [`BRD_PORT_CNT-1:0]   qsfp_lpmode_o,

    // host side
    input  logic [`BRD_PORT_CNT-1:0]   port_enable_i,
    input  logic                       evt_clr_stb_i,
    input  logic [1:0]                 evt_clr_port_i,
    output logic [3*`BRD_PORT_CNT-1:0] evt_flags_o,
    output logic                       irq_o,
    output logic [`BRD_PORT_CNT-1:0]   led_o
);

    logic [`BRD_PORT_CNT-1:0] modprsl_sync;
    logic [`BRD_PORT_CNT-1:0] intl_sync;

    // presence and interrupt pins share one synchronizer
    sig_sync #(
        .WIDTH  (2*`BRD_PORT_CNT),
        .STAGES (`BRD_SYNC_STAGES)
    ) u_sig_sync (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n_i        (rst_n_i),
        .async_i        ({qsfp_modprsl_i, qsfp_intl_i}),
        .sync_o         ({modprsl_sync, intl_sync})
    );

    qsfp_stat_if stat_if [`BRD_PORT_CNT] ();

    for (genvar i = 0; i < `BRD_PORT_CNT; i++) begin : g_mgr
        qsfp_port_mgr #(
            .RESET_HOLD (`BRD_RESET_HOLD),
            .INIT_WAIT  (`BRD_INIT_WAIT)
        ) u_qsfp_port_mgr (
            .clk_125mhz_int (clk_125mhz_int),
            .rst_n_i        (rst_n_i),
            .modprsl_i      (modprsl_sync[i]),
            .intl_i         (intl_sync[i]),
            .enable_i       (port_enable_i[i]),
            .resetl_o       (qsfp_resetl_o[i]),
            .lpmode_o       (qsfp_lpmode_o[i]),
            .stat           (stat_if[i])
        );
    end

    port_status_agg u_port_status_agg (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n_i        (rst_n_i),
        .stat           (stat_if),
        .evt_clr_stb_i  (evt_clr_stb_i),
        .evt_clr_port_i (evt_clr_port_i),
        .evt_flags_o    (evt_flags_o),
        .irq_o          (irq_o),
        .led_o          (led_o)
    );

endmodule

//--- verif/tb_clk_gen.sv
// tb_clk_gen module, testbench clock and synchronous reset
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 8.0,
    parameter int  RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // reset held low over the first edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- verif/tb_qsfp_mgmt.sv
// tb_qsfp_mgmt module, directed testbench for the qsfp sideband block
`timescale 1ns/10ps
`include "board_macros.svh"

module tb_qsfp_mgmt;
    import board_pkg::*;

    // edges from a pin change to each visible effect
    localparam int T_INS = `BRD_SYNC_STAGES + 2;
    localparam int T_RST = `BRD_SYNC_STAGES + 1 + `BRD_RESET_HOLD;
    localparam int T_LP  = T_RST + `BRD_INIT_WAIT;
    localparam int TIMEOUT_CYC = 8 * (`BRD_RESET_HOLD + `BRD_INIT_WAIT + 40);

    logic          clk_125mhz_int;
    logic          rst_n;
    port_mask_t    modprsl;
    port_mask_t    intl;
    port_mask_t    enable;
    port_mask_t    resetl;
    port_mask_t    lpmode;
    port_mask_t    led;
    logic          clr_stb;
    port_idx_t     clr_port;
    port_evt_arr_t flags;
    logic          irq;

    int         err_cnt = 0;
    int         chk_cnt = 0;
    int         cycle_cnt = 0;
    logic [7:0] lfsr_q = 8'd70;
    int         ins_off [`BRD_PORT_CNT];

    tb_clk_gen #(.PERIOD_NS(8.0), .RST_CYCLES(5)) u_tb_clk_gen (
        .clk_o   (clk_125mhz_int),
        .rst_n_o (rst_n)
    );

    qsfp_mgmt_top u_qsfp_mgmt_top (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_n_i        (rst_n),
        .qsfp_modprsl_i (modprsl),
        .qsfp_intl_i    (intl),
        .qsfp_resetl_o  (resetl),
        .qsfp_lpmode_o  (lpmode),
        .port_enable_i  (enable),
        .evt_clr_stb_i  (clr_stb),
        .evt_clr_port_i (clr_port),
        .evt_flags_o    (flags),
        .irq_o          (irq),
        .led_o          (led)
    );

    always @(posedge clk_125mhz_int) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout: tests still running after %0d cycles", cycle_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    // galois form, taps at 8, 6, 5 and 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 8'hB8;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic port_evt_arr_t evt_of(input port_mask_t ins, input port_mask_t rem,
                                             input port_mask_t intr);
        port_evt_arr_t e;
        for (int p = 0; p < `BRD_PORT_CNT; p++) begin
            e[p].insert = ins[p];
            e[p].remove = rem[p];
            e[p].intr   = intr[p];
        end
        return e;
    endfunction

    task automatic cmp_mask(input string name, input port_mask_t exp, input port_mask_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("error at %0t ns: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic cmp_evt(input string name, input port_evt_arr_t exp,
                           input port_evt_arr_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic cmp_bit(input string name, input logic exp, input logic act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("error at %0t ns: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_outputs(input port_mask_t exp_rst, input port_mask_t exp_lp,
                                 input port_mask_t exp_led, input port_evt_arr_t exp_evt,
                                 input logic exp_irq);
        cmp_mask("qsfp_resetl_o", exp_rst, resetl);
        cmp_mask("qsfp_lpmode_o", exp_lp, lpmode);
        cmp_mask("led_o", exp_led, led);
        cmp_evt("evt_flags_o", exp_evt, flags);
        cmp_bit("irq_o", exp_irq, irq);
    endtask

    task automatic wait_edges(input int n);
        repeat (n) @(posedge clk_125mhz_int);
    endtask

    // one-cycle clear strobe, returns on the edge that takes it
    task automatic clear_port(input int idx);
        @(posedge clk_125mhz_int);
        clr_stb  <= 1'b1;
        clr_port <= port_idx_t'(idx);
        @(posedge clk_125mhz_int);
        clr_stb  <= 1'b0;
    endtask

    // pull every module, re-enable only once the pins are seen high
    task automatic remove_all();
        @(posedge clk_125mhz_int);
        modprsl <= '1;
        intl    <= '1;
        wait_edges(4);
        enable <= '1;
        wait_edges(1);
        for (int p = 0; p < `BRD_PORT_CNT; p++) begin
            clear_port(p);
        end
        wait_edges(1);
        @(negedge clk_125mhz_int);
        check_outputs('0, '1, '0, '0, 1'b0);
    endtask

    // insert cages at ins_off and check every output on every cycle
    task automatic track_power_up(input int span);
        port_mask_t exp_rst;
        port_mask_t exp_lp;
        port_mask_t exp_led;
        port_mask_t exp_ins;
        logic       exp_irq;
        int         first;
        int         age;
        first = -1;
        for (int p = 0; p < `BRD_PORT_CNT; p++) begin
            if (ins_off[p] >= 0 && (first < 0 || ins_off[p] < first)) begin
                first = ins_off[p];
            end
        end
        for (int t = 0; t < span; t++) begin
            @(posedge clk_125mhz_int);
            for (int p = 0; p < `BRD_PORT_CNT; p++) begin
                if (ins_off[p] == t) begin
                    modprsl[p] <= 1'b0;
                end
            end
            @(negedge clk_125mhz_int);
            for (int p = 0; p < `BRD_PORT_CNT; p++) begin
                // edges since this pin fell
                age = (ins_off[p] < 0) ? -1 : t - ins_off[p];
                exp_rst[p] = (age >= T_RST);
                exp_lp[p]  = !(age >= T_LP);
                exp_led[p] = (age >= T_LP + 1);
                exp_ins[p] = (age >= T_INS);
            end
            exp_irq = (first >= 0) && (t - first >= T_INS + 1);
            check_outputs(exp_rst, exp_lp, exp_led, evt_of(exp_ins, '0, '0), exp_irq);
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk_125mhz_int);
        check_outputs('0, '1, '0, '0, 1'b0);
    endtask

    task automatic run_single_power_up();
        ins_off = '{-1, 0, -1, -1};
        track_power_up(T_LP + 4);
        remove_all();
    endtask

    task automatic abort_sequences();
        // disable and removal in hold, then in init
        @(posedge clk_125mhz_int);
        modprsl <= '0;
        wait_edges(6);
        enable[0]  <= 1'b0;
        modprsl[1] <= 1'b1;
        wait_edges(5);
        @(negedge clk_125mhz_int);
        check_outputs('0, '1, '0, evt_of(4'b1111, 4'b0011, '0), 1'b1);
        wait_edges(14);
        enable[2]  <= 1'b0;
        modprsl[3] <= 1'b1;
        @(negedge clk_125mhz_int);
        check_outputs(4'b1100, '1, '0, evt_of(4'b1111, 4'b0011, '0), 1'b1);
        wait_edges(5);
        @(negedge clk_125mhz_int);
        check_outputs('0, '1, '0, evt_of(4'b1111, 4'b1111, '0), 1'b1);
        remove_all();
        // abort in ready, port 3 present but never enabled
        @(posedge clk_125mhz_int);
        enable  <= 4'b0111;
        modprsl <= '0;
        wait_edges(T_LP + 2);
        @(negedge clk_125mhz_int);
        check_outputs(4'b0111, 4'b1000, 4'b0111, evt_of(4'b0111, '0, '0), 1'b1);
        @(posedge clk_125mhz_int);
        enable     <= 4'b0110;
        modprsl[1] <= 1'b1;
        wait_edges(5);
        @(negedge clk_125mhz_int);
        check_outputs(4'b0100, 4'b1011, 4'b0100, evt_of(4'b0111, 4'b0011, '0), 1'b1);
        remove_all();
    endtask

    task automatic module_interrupts();
        @(posedge clk_125mhz_int);
        modprsl <= 4'b1000;
        // port 1 pulses intl in hold
        wait_edges(6);
        intl[1] <= 1'b0;
        wait_edges(4);
        intl[1] <= 1'b1;
        // port 2 pulses intl in init
        wait_edges(15);
        intl[2] <= 1'b0;
        wait_edges(4);
        intl[2] <= 1'b1;
        wait_edges(24);
        @(negedge clk_125mhz_int);
        check_outputs(4'b0111, 4'b1000, 4'b0111, evt_of(4'b0111, '0, '0), 1'b1);
        @(posedge clk_125mhz_int);
        intl[0] <= 1'b0;
        wait_edges(5);
        @(negedge clk_125mhz_int);
        check_outputs(4'b0111, 4'b1000, 4'b0111, evt_of(4'b0111, '0, 4'b0001), 1'b1);
    endtask

    task automatic clear_per_port();
        @(posedge clk_125mhz_int);
        intl[0] <= 1'b1;
        wait_edges(3);
        clear_port(1);
        @(negedge clk_125mhz_int);
        check_outputs(4'b0111, 4'b1000, 4'b0111, evt_of(4'b0101, '0, 4'b0001), 1'b1);
        // intr strobe of port 2 lands on the same edge as its clear
        @(posedge clk_125mhz_int);
        intl[2] <= 1'b0;
        wait_edges(3);
        clr_stb  <= 1'b1;
        clr_port <= 2'd2;
        wait_edges(1);
        clr_stb <= 1'b0;
        intl[2] <= 1'b1;
        @(negedge clk_125mhz_int);
        check_outputs(4'b0111, 4'b1000, 4'b0111, evt_of(4'b0001, '0, 4'b0101), 1'b1);
        clear_port(0);
        @(negedge clk_125mhz_int);
        check_outputs(4'b0111, 4'b1000, 4'b0111, evt_of('0, '0, 4'b0100), 1'b1);
        clear_port(2);
        @(negedge clk_125mhz_int);
        check_outputs(4'b0111, 4'b1000, 4'b0111, '0, 1'b1);
        @(negedge clk_125mhz_int);
        cmp_bit("irq_o", 1'b0, irq);
        remove_all();
    endtask

    task automatic four_port_power_up();
        int order [`BRD_PORT_CNT];
        int r;
        int tmp;
        int cur;
        for (int p = 0; p < `BRD_PORT_CNT; p++) begin
            order[p] = p;
        end
        for (int i = `BRD_PORT_CNT - 1; i > 0; i--) begin
            take_bits(2, r);
            tmp = order[i];
            order[i] = order[r % (i + 1)];
            order[r % (i + 1)] = tmp;
        end
        take_bits(2, cur);
        for (int k = 0; k < `BRD_PORT_CNT; k++) begin
            ins_off[order[k]] = cur;
            take_bits(2, r);
            cur = cur + 1 + r;
        end
        track_power_up(cur + T_LP + 4);
        remove_all();
    endtask

    initial begin
        modprsl  = '1;
        intl     = '1;
        enable   = '1;
        clr_stb  = 1'b0;
        clr_port = '0;
        wait (rst_n === 1'b1);
        check_reset_state();
        run_single_power_up();
        abort_sequences();
        module_interrupts();
        clear_per_port();
        four_port_power_up();
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+design
design/board_pkg.sv
design/qsfp_stat_if.sv
design/sig_sync.sv
design/qsfp_port_mgr.sv
design/port_status_agg.sv
design/qsfp_mgmt_top.sv
verif/tb_clk_gen.sv
verif/tb_qsfp_mgmt.sv

//--- Bender.yml
package:
  name: qsfp_mgmt

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/board_pkg.sv
      - design/qsfp_stat_if.sv
      - design/sig_sync.sv
      - design/qsfp_port_mgr.sv
      - design/port_status_agg.sv
      - design/qsfp_mgmt_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_qsfp_mgmt.sv
